/* Makefile */
VERILATOR  ?= verilator
TOP        ?= mdu_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF '$(PASS_TEXT)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/mdu_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module mdu_chk (
    input wire logic                     clk,
    input wire logic                     reset,
    input wire logic                     done,
    input wire logic                     div_rdy,
    input wire mdu_ctrl_pkg::dp_ctrl_t   ctrl,
    input wire mdu_ctrl_pkg::mdu_state_t state
);

    logic done_bad  = 1'b0;
    logic start_bad = 1'b0;
    logic load_bad  = 1'b0;
    logic any_fail;
    logic busy_q; // A slow operation is loaded and not yet answered

    assign any_fail = done_bad | start_bad | load_bad; // Polled by the testbench

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy_q <= 1'b0;
        end else if (ctrl.opnd_en) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    // Start is a one-cycle pulse, so done never stretches
    done_pulse: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            done_bad = 1'b1;
        end

    // The divider answers only while the controller is still requesting it
    div_handoff: assert property (@(posedge clk) disable iff (!reset)
        div_rdy |-> $fell(ctrl.div_start))
        else begin
            $error("div_rdy came without div_start falling");
            start_bad = 1'b1;
        end

    opnd_load_idle: assert property (@(posedge clk) disable iff (!reset)
        ctrl.opnd_en |-> (state == mdu_ctrl_pkg::IDLE) && !busy_q)
        else begin
            $error("operand register loaded while an operation was pending");
            load_bad = 1'b1;
        end

endmodule

`default_nettype wire

/* bench/mdu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_tb;

    localparam int XLEN         = `MDU_XLEN;
    localparam int RESET_CYCLES = 5;
    localparam int N_RAND       = 8;
    localparam int OP_CYCLES    = `MDU_DIV_STEPS + 8;     // Longest operation plus margin
    localparam int NUM_OPS      = 48 + 8 * N_RAND + 12 + 3;
    localparam int MAX_CYCLES   = 2 * (NUM_OPS * (OP_CYCLES + 2) + 4 * RESET_CYCLES);
    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

    logic                  clk;
    logic                  reset;
    logic                  start;
    mdu_isa_pkg::mdu_req_t req_in;
    logic [XLEN-1:0]       result;
    logic                  done;
    int                    cycle_count = 0;

    mdu_top mdu_top_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .req    (req_in),
        .result (result),
        .done   (done)
    );

    bind mdu_ctrl mdu_chk mdu_chk_i (
        .clk     (clk),
        .reset   (reset),
        .done    (done),
        .div_rdy (div_rdy),
        .ctrl    (ctrl),
        .state   (state_q)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1);
        end else if (mdu_top_i.mdu_ctrl_i.mdu_chk_i.any_fail) begin
            $display("A controller assertion failed");
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // RISC-V M-extension reference results
    function automatic logic [XLEN-1:0] golden(input mdu_isa_pkg::mdu_req_t r);
        logic signed [2*XLEN:0] ax;
        logic signed [2*XLEN:0] bx;
        logic signed [2*XLEN:0] prod;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   a_sgn;
        logic                   b_sgn;
        sa = r.a;
        sb = r.b;
        if (!r.is_div) begin
            a_sgn = (r.mul_op != mdu_isa_pkg::MULHU);
            b_sgn = (r.mul_op == mdu_isa_pkg::MUL) || (r.mul_op == mdu_isa_pkg::MULH);
            ax    = {{(XLEN+1){a_sgn & r.a[XLEN-1]}}, r.a};
            bx    = {{(XLEN+1){b_sgn & r.b[XLEN-1]}}, r.b};
            prod  = ax * bx; // Low 2*XLEN bits are exact
            return (r.mul_op == mdu_isa_pkg::MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
        end
        if (r.b == '0) return r.div_op[1] ? r.a : '1;
        if (r.div_op[0]) return r.div_op[1] ? r.a % r.b : r.a / r.b;
        if (r.a == MIN_VAL && r.b == '1) return r.div_op[1] ? '0 : MIN_VAL; // Overflow
        return r.div_op[1] ? sa % sb : sa / sb;
    endfunction

    // With one special operand the table misses an all-ones operand read as unsigned
    // and a signed high word that needs the sign of the other operand
    function automatic logic expect_fast(input mdu_isa_pkg::mdu_req_t r);
        logic a_m1;
        logic b_m1;
        logic one_neg;
        logic m1_min;
        a_m1    = (r.a == '1);
        b_m1    = (r.b == '1);
        one_neg = (r.a == XLEN'(1) && r.b[XLEN-1]) || (r.b == XLEN'(1) && r.a[XLEN-1]);
        m1_min  = (a_m1 && r.b == MIN_VAL) || (b_m1 && r.a == MIN_VAL);
        if (r.a == '0 || r.b == '0) return 1'b1;
        if (r.is_div) return !r.div_op[0] || !(a_m1 || b_m1);
        case (r.mul_op)
            mdu_isa_pkg::MUL:    return 1'b1;
            mdu_isa_pkg::MULH:   return !one_neg && !m1_min;
            mdu_isa_pkg::MULHSU: return !b_m1;
            default:             return !(a_m1 || b_m1);
        endcase
    endfunction

    function automatic mdu_isa_pkg::mdu_req_t make_req(input logic is_div, input logic [1:0] op,
                                                       input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b);
        mdu_isa_pkg::mdu_req_t r;
        r.is_div = is_div;
        r.mul_op = mdu_isa_pkg::mul_op_t'(op);
        r.div_op = mdu_isa_pkg::div_op_t'(op);
        r.a      = a;
        r.b      = b;
        return r;
    endfunction

    // Never 0, 1 or all-ones
    function automatic logic [XLEN-1:0] rand_plain();
        logic [XLEN-1:0] v;
        v = $urandom;
        return (v & ~XLEN'(2)) | XLEN'(32'h100);
    endfunction

    function automatic logic [XLEN-1:0] special_val(input int k);
        if (k == 0) return '0;
        if (k == 1) return XLEN'(1);
        return '1;
    endfunction

    task automatic check_result(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_req_done(input logic got, input logic exp, input string what);
        if (exp && got !== 1'b1) begin
            $display("The done pulse never came for %s", what);
            $display("** FAIL **");
            $fatal(1);
        end else if (!exp && got !== 1'b0) begin
            $display("MISMATCH done %s: got %h, expected %h", what, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // One request, latency counted in cycles after the start cycle
    task automatic run_op(input mdu_isa_pkg::mdu_req_t r, output int lat,
                          output logic [XLEN-1:0] res);
        @(posedge clk);
        #1;
        req_in = r;
        start  = 1'b1;
        @(negedge clk);
        lat = 0;
        while (!done && lat < OP_CYCLES) begin
            @(posedge clk);
            #1;
            start = 1'b0;
            @(negedge clk);
            lat++;
        end
        check_req_done(done, 1'b1, $sformatf("a=%h b=%h", r.a, r.b));
        res = result;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic run_check(input string name, input mdu_isa_pkg::mdu_req_t r,
                             input logic [XLEN-1:0] exp);
        int              lat;
        logic [XLEN-1:0] res;
        run_op(r, lat, res);
        check_result(name, res, exp);
    endtask

    task automatic test_fast_results();
        mdu_isa_pkg::mdu_req_t r;
        int                    lat;
        logic [XLEN-1:0]       res;
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < 6; k++) begin
                if (k < 3) r = make_req(op[2], op[1:0], special_val(k), rand_plain());
                else r = make_req(op[2], op[1:0], rand_plain(), special_val(k - 3));
                run_op(r, lat, res);
                check_result("fast result", res, golden(r));
                if (expect_fast(r)) check_count("fast latency", lat, 0);
                else if (!r.is_div) check_count("mul latency", lat, 3);
            end
        end
    endtask

    task automatic test_mul_slow();
        mdu_isa_pkg::mdu_req_t r;
        int                    lat;
        logic [XLEN-1:0]       res;
        for (int i = 0; i < N_RAND; i++) begin
            for (int op = 0; op < 4; op++) begin
                r = make_req(1'b0, op[1:0], rand_plain(), rand_plain());
                run_op(r, lat, res);
                check_count("mul latency", lat, 3);
                check_result("product", res, golden(r));
            end
        end
    endtask

    task automatic test_div_slow();
        mdu_isa_pkg::mdu_req_t r;
        for (int i = 0; i < N_RAND; i++) begin
            for (int op = 0; op < 4; op++) begin
                // Shrinking divisors give quotients of every size
                r = make_req(1'b1, op[1:0], rand_plain(), (rand_plain() >> (i * 3)) | XLEN'(4));
                run_check("divide result", r, golden(r));
            end
        end
    endtask

    task automatic test_corners();
        logic [XLEN-1:0] x;
        x = rand_plain();
        run_check("DIV by zero", make_req(1'b1, 2'b00, x, '0), '1);
        run_check("DIVU by zero", make_req(1'b1, 2'b01, x, '0), '1);
        run_check("REM by zero", make_req(1'b1, 2'b10, x, '0), x);
        run_check("REMU by zero", make_req(1'b1, 2'b11, x, '0), x);
        run_check("DIV overflow", make_req(1'b1, 2'b00, MIN_VAL, '1), MIN_VAL);
        run_check("REM overflow", make_req(1'b1, 2'b10, MIN_VAL, '1), '0);
        run_check("MULH min by -1", make_req(1'b0, 2'b01, MIN_VAL, '1), '0);
        run_check("MULH -1 by min", make_req(1'b0, 2'b01, '1, MIN_VAL), '0);
        run_check("MUL min by -1", make_req(1'b0, 2'b00, MIN_VAL, '1), MIN_VAL);
        run_check("DIVU by all-ones", make_req(1'b1, 2'b01, x, '1), '0);
        run_check("DIVU all-ones", make_req(1'b1, 2'b01, '1, '1), XLEN'(1));
        run_check("REMU by all-ones", make_req(1'b1, 2'b11, x, '1), x);
    endtask

    task automatic test_busy_and_reset();
        mdu_isa_pkg::mdu_req_t div_r;
        logic [XLEN-1:0]       seen_res;
        int                    dones;
        div_r = make_req(1'b1, 2'b01, XLEN'(1000), XLEN'(7));
        @(posedge clk);
        #1;
        req_in = div_r;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        req_in = make_req(1'b0, 2'b00, rand_plain(), rand_plain()); // Must be ignored
        start  = 1'b1;
        @(posedge clk);
        #1;
        start    = 1'b0;
        dones    = 0;
        seen_res = '0;
        repeat (OP_CYCLES + 4) begin
            @(negedge clk);
            if (done) begin
                dones++;
                seen_res = result;
            end
        end
        check_count("done count", dones, 1);
        check_result("busy result", seen_res, golden(div_r));
        // Reset in the middle of a divide drops it
        @(posedge clk);
        #1;
        req_in = div_r;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_req_done(done, 1'b0, "in reset");
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (OP_CYCLES) begin
            @(negedge clk);
            check_req_done(done, 1'b0, "after reset");
            check_result("result after reset", result, '0);
        end
    endtask

    initial begin
        reset  = 1'b0;
        start  = 1'b0;
        req_in = '0;
        void'($urandom(32'h9dc4));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;
        test_fast_results();
        test_mul_slow();
        test_div_slow();
        test_corners();
        test_busy_and_reset();
        repeat (2) @(posedge clk);
        if (mdu_top_i.mdu_ctrl_i.mdu_chk_i.any_fail) begin
            $display("A controller assertion failed");
            $display("** FAIL **");
            $fatal(1);
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
hdl/mdu_isa_pkg.sv
hdl/mdu_ctrl_pkg.sv
hdl/mdu_operand_class.sv
hdl/mdu_ctrl.sv
hdl/mdu_mul.sv
hdl/mdu_div.sv
hdl/mdu_top.sv
bench/mdu_chk.sv
bench/mdu_tb.sv

/* hdl/mdu_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_ctrl (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire mdu_isa_pkg::mdu_req_t  req,
    input  wire mdu_ctrl_pkg::opnd_info_t info,
    input  wire logic                   div_rdy,
    output mdu_ctrl_pkg::dp_ctrl_t      ctrl,
    output logic                        fast_hit,
    output logic [`MDU_XLEN-1:0]        fast_result,
    output logic                        done
);

    localparam int XLEN = `MDU_XLEN;

    mdu_ctrl_pkg::ab_status_t st;
    mdu_ctrl_pkg::mdu_state_t state_q;
    mdu_ctrl_pkg::mdu_state_t state_d;

    logic            a_min; // a is 0x80000000
    logic            b_min;
    logic            mul_hit;
    logic [XLEN-1:0] mul_res;
    logic            div_hit;
    logic [XLEN-1:0] div_res;
    logic            table_hit;

    assign st = info.status;

    // Only the most negative value keeps its sign bit through negation
    assign a_min = req.a[XLEN-1] & info.a_neg[XLEN-1];
    assign b_min = req.b[XLEN-1] & info.b_neg[XLEN-1];

    // Multiply table, one row per special operand in priority order
    always_comb begin
        mul_hit = 1'b1;
        mul_res = '0;
        if (st.a_zero || st.b_zero) begin
            mul_res = '0;
        end else if (st.a_one) begin
            if (req.mul_op == mdu_isa_pkg::MUL) mul_res = req.b;
            else if (req.mul_op == mdu_isa_pkg::MULH) mul_hit = ~req.b[XLEN-1];
        end else if (st.b_one) begin
            case (req.mul_op)
                mdu_isa_pkg::MUL:    mul_res = req.a;
                mdu_isa_pkg::MULH:   mul_hit = ~req.a[XLEN-1];
                mdu_isa_pkg::MULHSU: mul_res = {XLEN{req.a[XLEN-1]}}; // Sign of a
                default:             mul_res = '0;
            endcase
        end else if (st.a_m1) begin
            case (req.mul_op)
                mdu_isa_pkg::MUL:    mul_res = info.b_neg;
                mdu_isa_pkg::MULH: begin
                    mul_res = {XLEN{~req.b[XLEN-1]}};
                    mul_hit = ~b_min; // -1 * 0x80000000 is positive
                end
                mdu_isa_pkg::MULHSU: mul_res = '1; // -b with b unsigned and nonzero
                default:             mul_hit = 1'b0;
            endcase
        end else if (st.b_m1) begin
            if (req.mul_op == mdu_isa_pkg::MUL) begin
                mul_res = info.a_neg;
            end else if (req.mul_op == mdu_isa_pkg::MULH) begin
                mul_res = {XLEN{~req.a[XLEN-1]}};
                mul_hit = ~a_min;
            end else begin
                mul_hit = 1'b0; // b is 2**XLEN-1 when unsigned
            end
        end else begin
            mul_hit = 1'b0;
        end
    end

    // Divide table, remainder selected by div_op[1]
    always_comb begin
        div_hit = 1'b1;
        div_res = '0;
        if (st.b_zero) begin
            div_res = req.div_op[1] ? req.a : '1; // RISC-V divide by zero
        end else if (st.a_zero) begin
            div_res = '0;
        end else if (st.b_one) begin
            div_res = req.div_op[1] ? '0 : req.a;
        end else if (st.b_m1) begin
            div_res = req.div_op[1] ? '0 : info.a_neg; // Overflow wraps to 0x80000000
            div_hit = ~req.div_op[0];
        end else if (st.a_one) begin
            div_res = req.div_op[1] ? XLEN'(1) : '0; // Divisor magnitude is at least 2
        end else if (st.a_m1) begin
            div_res = req.div_op[1] ? '1 : '0;
            div_hit = ~req.div_op[0];
        end else begin
            div_hit = 1'b0;
        end
    end

    assign table_hit   = req.is_div ? div_hit : mul_hit;
    assign fast_result = req.is_div ? div_res : mul_res;
    assign fast_hit    = (state_q == mdu_ctrl_pkg::IDLE) && start && table_hit;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= mdu_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        ctrl    = '0;
        done    = 1'b0;
        case (state_q)
            mdu_ctrl_pkg::IDLE: begin
                if (start && table_hit) begin
                    done = 1'b1; // Answer in the start cycle
                end else if (start) begin
                    ctrl.opnd_en = 1'b1;
                    state_d = req.is_div ? mdu_ctrl_pkg::DIV_WAIT : mdu_ctrl_pkg::MUL1;
                end
            end
            mdu_ctrl_pkg::DIV_WAIT: begin
                ctrl.res_from_div = 1'b1;
                if (div_rdy) begin
                    ctrl.res_en = 1'b1;
                    state_d     = mdu_ctrl_pkg::DIV_OUT;
                end else begin
                    ctrl.div_start = 1'b1;
                end
            end
            mdu_ctrl_pkg::DIV_OUT: begin
                done    = 1'b1;
                state_d = mdu_ctrl_pkg::IDLE;
            end
            mdu_ctrl_pkg::MUL1: state_d = mdu_ctrl_pkg::MUL2; // Partial products registered
            mdu_ctrl_pkg::MUL2: begin
                ctrl.res_en = 1'b1;
                state_d     = mdu_ctrl_pkg::MUL_OUT;
            end
            mdu_ctrl_pkg::MUL_OUT: begin
                done    = 1'b1;
                state_d = mdu_ctrl_pkg::IDLE;
            end
            default: state_d = mdu_ctrl_pkg::IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mdu_ctrl_pkg.sv */
`default_nettype none

`include "mdu_settings.svh"

package mdu_ctrl_pkg;

    typedef struct packed {
        logic b_m1;
        logic b_one;
        logic b_zero;
        logic a_m1;
        logic a_one;
        logic a_zero;
    } ab_status_t;

    typedef struct packed {
        ab_status_t           status;
        logic [`MDU_XLEN-1:0] a_neg; // Two's complement of a
        logic [`MDU_XLEN-1:0] b_neg; // Two's complement of b
    } opnd_info_t;

    typedef enum logic [2:0] {
        IDLE, DIV_WAIT, DIV_OUT, MUL1, MUL2, MUL_OUT
    } mdu_state_t;

    typedef struct packed {
        logic opnd_en;      // Load operand register
        logic res_en;       // Load result register
        logic res_from_div; // Result register source is the divider
        logic div_start;    // Held until the divider is ready
    } dp_ctrl_t;

endpackage

`default_nettype wire

/* hdl/mdu_div.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_div (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire mdu_isa_pkg::mdu_req_t  req,
    input  wire logic                   div_start,
    output logic [`MDU_XLEN-1:0]        quotient,
    output logic [`MDU_XLEN-1:0]        remainder,
    output logic                        rdy
);

    localparam int XLEN = `MDU_XLEN;
    localparam int CW   = $clog2(`MDU_DIV_STEPS + 1);

    logic            running_q;
    logic            fin_q;
    logic [CW-1:0]   count_q;
    logic [XLEN-1:0] quot_q;  // Dividend shifts out as quotient bits shift in
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dsor_q;
    logic            q_neg_q;
    logic            r_neg_q;
    logic            signed_op;
    logic            a_sign;
    logic            b_sign;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;
    logic            load;

    assign signed_op = ~req.div_op[0];
    assign a_sign    = signed_op & req.a[XLEN-1];
    assign b_sign    = signed_op & req.b[XLEN-1];
    assign a_mag     = a_sign ? -req.a : req.a;
    assign b_mag     = b_sign ? -req.b : req.b;
    assign load      = div_start & ~running_q & ~fin_q; // Idle only

    assign shifted = {rem_q, quot_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dsor_q};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            running_q <= 1'b0;
            fin_q     <= 1'b0;
            count_q   <= '0;
        end else begin
            fin_q <= 1'b0;
            if (load) begin
                running_q <= 1'b1;
                count_q   <= CW'(`MDU_DIV_STEPS);
            end else if (running_q) begin
                count_q <= count_q - 1'b1;
                if (count_q == CW'(1)) begin // Last step
                    running_q <= 1'b0;
                    fin_q     <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quot_q  <= a_mag;
            rem_q   <= '0;
            dsor_q  <= b_mag;
            q_neg_q <= a_sign ^ b_sign;
            r_neg_q <= a_sign; // Remainder follows the dividend
        end else if (running_q) begin
            if (!diff[XLEN]) begin
                rem_q  <= diff[XLEN-1:0];
                quot_q <= {quot_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[XLEN-1:0];
                quot_q <= {quot_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // A zero divisor leaves the all-ones quotient unsigned
    assign quotient  = (q_neg_q && dsor_q != '0) ? -quot_q : quot_q;
    assign remainder = r_neg_q ? -rem_q : rem_q;
    assign rdy       = fin_q;

endmodule

`default_nettype wire

/* hdl/mdu_isa_pkg.sv */
`default_nettype none

`include "mdu_settings.svh"

package mdu_isa_pkg;

    // funct3[1:0] of the multiply group
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_t;

    // Bit 1 selects remainder, bit 0 selects unsigned
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    typedef struct packed {
        logic                 is_div; // Divide group when set
        mul_op_t              mul_op;
        div_op_t              div_op;
        logic [`MDU_XLEN-1:0] a;
        logic [`MDU_XLEN-1:0] b;
    } mdu_req_t;

endpackage

`default_nettype wire

/* hdl/mdu_mul.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_mul (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire mdu_isa_pkg::mdu_req_t  req,
    output logic [`MDU_XLEN-1:0]        product
);

    localparam int XLEN = `MDU_XLEN;
    localparam int HALF = XLEN / 2;
    localparam int PPW  = XLEN + 1 + XLEN - HALF + 1; // Partial product width

    logic                          a_signed;
    logic                          b_signed;
    logic signed [XLEN:0]          a_ext;
    logic signed [XLEN-HALF:0]     b_hi;    // Upper half of b, sign carried
    logic signed [HALF:0]          b_lo;    // Lower half of b, always positive
    logic signed [PPW-1:0]         pp_hi;
    logic signed [PPW-1:0]         pp_lo;
    logic signed [PPW-1:0]         pp_hi_q;
    logic signed [PPW-1:0]         pp_lo_q;
    logic                          hi_sel_q;
    logic signed [2*XLEN+1:0]      sum;

    assign a_signed = (req.mul_op != mdu_isa_pkg::MULHU);
    assign b_signed = ~req.mul_op[1]; // MUL and MULH
    assign a_ext    = {a_signed & req.a[XLEN-1], req.a};
    assign b_hi     = {b_signed & req.b[XLEN-1], req.b[XLEN-1:HALF]};
    assign b_lo     = {1'b0, req.b[HALF-1:0]};

    assign pp_hi = a_ext * b_hi;
    assign pp_lo = a_ext * b_lo;

    always_ff @(posedge clk) begin
        pp_hi_q <= pp_hi;
        pp_lo_q <= pp_lo;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            hi_sel_q <= 1'b0;
        end else begin
            hi_sel_q <= (req.mul_op != mdu_isa_pkg::MUL);
        end
    end

    // Stage 2 combines the halves and picks a word
    assign sum     = (pp_hi_q <<< HALF) + pp_lo_q;
    assign product = hi_sel_q ? sum[2*XLEN-1:XLEN] : sum[XLEN-1:0];

endmodule

`default_nettype wire

/* hdl/mdu_operand_class.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_operand_class (
    input  wire logic [`MDU_XLEN-1:0]   a,
    input  wire logic [`MDU_XLEN-1:0]   b,
    output mdu_ctrl_pkg::opnd_info_t    info
);

    localparam int XLEN = `MDU_XLEN;

    logic [XLEN-1:0] a_neg;
    logic [XLEN-1:0] b_neg;

    // Negation feeds the fast table for the -1 cases
    assign a_neg = ~a + XLEN'(1);
    assign b_neg = ~b + XLEN'(1);

    always_comb begin
        info.status.a_zero = (a == '0);
        info.status.a_one  = (a == XLEN'(1));
        info.status.a_m1   = (a == '1);
        info.status.b_zero = (b == '0);
        info.status.b_one  = (b == XLEN'(1));
        info.status.b_m1   = (b == '1);
        info.a_neg         = a_neg;
        info.b_neg         = b_neg;
    end

endmodule

`default_nettype wire

/* hdl/mdu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire mdu_isa_pkg::mdu_req_t  req,
    output logic [`MDU_XLEN-1:0]        result,
    output logic                        done
);

    localparam int XLEN = `MDU_XLEN;

    mdu_isa_pkg::mdu_req_t    req_q;    // Operands for the slow paths
    mdu_ctrl_pkg::opnd_info_t info;
    mdu_ctrl_pkg::dp_ctrl_t   ctrl;
    logic                     fast_hit;
    logic [XLEN-1:0]          fast_result;
    logic [XLEN-1:0]          product;
    logic [XLEN-1:0]          quotient;
    logic [XLEN-1:0]          remainder;
    logic                     div_rdy;
    logic [XLEN-1:0]          res_d;
    logic [XLEN-1:0]          res_q;

    mdu_operand_class mdu_operand_class_i (
        .a    (req.a),
        .b    (req.b),
        .info (info)
    );

    mdu_ctrl mdu_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .req         (req),
        .info        (info),
        .div_rdy     (div_rdy),
        .ctrl        (ctrl),
        .fast_hit    (fast_hit),
        .fast_result (fast_result),
        .done        (done)
    );

    mdu_mul mdu_mul_i (
        .clk     (clk),
        .reset   (reset),
        .req     (req_q),
        .product (product)
    );

    mdu_div mdu_div_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req_q),
        .div_start (ctrl.div_start),
        .quotient  (quotient),
        .remainder (remainder),
        .rdy       (div_rdy)
    );

    always_ff @(posedge clk) begin
        if (ctrl.opnd_en) req_q <= req;
    end

    assign res_d = !ctrl.res_from_div ? product :
                   req_q.div_op[1]    ? remainder : quotient;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            res_q <= '0;
        end else if (ctrl.res_en) begin
            res_q <= res_d;
        end
    end

    assign result = fast_hit ? fast_result : res_q; // Fast answers bypass the register

endmodule

`default_nettype wire

/* include/mdu_settings.svh */
`ifndef MDU_SETTINGS_SVH
`define MDU_SETTINGS_SVH

// Operand and result width
`define MDU_XLEN 32

// One radix-2 step per quotient bit
`define MDU_DIV_STEPS `MDU_XLEN

`endif
